/* filelist.f */
+incdir+.
lsu_pkg.sv
store_buffer.sv
store_drain.sv
load_gate.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

/* load_gate.sv */
// ----------------------------------------
// One-entry load holding register, released
// to memory once no store collides
// ----------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_gate import lsu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   ld_valid_i,   // Load strobe from execute
    input  ld_req_t                ld_req_i,
    input  logic                   collision_i,  // From the store buffer check
    output logic [`LSU_ADDR_W-1:0] check_addr_o, // Held load address for the check
    output mem_size_t              check_size_o,
    output logic                   busy_o,       // A load is held
    output logic                   mem_rd_o,     // One cycle read strobe
    output ld_req_t                mem_rd_req_o
);

    ld_req_t held_q;   // Payload, no reset
    logic    busy_q;
    logic    release_ld;

    // Goes out in the first held cycle without collision
    assign release_ld = busy_q & ~collision_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
        end else if (ld_valid_i) begin
            busy_q <= 1'b1;
        end else if (release_ld) begin
            busy_q <= 1'b0; // Clears on the strobe edge
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_valid_i) begin
            held_q <= ld_req_i;
        end
    end

    // Flush leaves the held load alone, it waits out the check

    assign check_addr_o = held_q.addr;
    assign check_size_o = held_q.size;
    assign busy_o       = busy_q;
    assign mem_rd_o     = release_ld;
    assign mem_rd_req_o = held_q;

endmodule

/* lsu_defs.svh */
// ----------------------------------------
// Store buffer depth, bus widths and
// memory access size codes
// ----------------------------------------
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

`define ST_BUF_NUM_ENTRIES 8 // Power of two

`define LSU_ADDR_W 64
`define LSU_DATA_W 64

`define SIZE_B 4'b0000 // Byte
`define SIZE_H 4'b0001 // Half word
`define SIZE_W 4'b0010 // Word
`define SIZE_D 4'b0011 // Double word
`define SIZE_Q 4'b0111 // Quad word

`endif

/* lsu_pkg.sv */
// ----------------------------------------
// LSU types: size code, store, load and
// memory write request structs
// ----------------------------------------
`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [3:0] mem_size_t; // Access size code, see SIZE_* macros

    // One store as it leaves execute
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
        mem_size_t              size;
        logic [3:0]             tag;  // Tracing only
    } st_req_t;

    // One load, also used as the memory read request
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        mem_size_t              size;
        logic [3:0]             tag;
    } ld_req_t;

    // Write request towards data memory
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
        mem_size_t              size;
    } mem_wr_t;

endpackage

/* lsu_properties.sv */
// ----------------------------------------
// Protocol assertions bound to lsu_top
// ----------------------------------------
`timescale 1ns/1ps

module lsu_properties (
    input logic clk_i,
    input logic rstn_i,
    input logic flush_i,
    input logic st_empty_o,
    input logic st_full_o,
    input logic ld_busy_o,
    input logic mem_wr_o,
    input logic mem_wr_ack_i,
    input logic mem_rd_o,
    input logic collision   // Internal collision flag of the top level
);

    logic outstanding; // Write issued, acknowledge not seen yet

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            outstanding <= 1'b0;
        end else if (flush_i || mem_wr_ack_i) begin
            outstanding <= 1'b0; // Flush abandons the write
        end else if (mem_wr_o) begin
            outstanding <= 1'b1;
        end
    end

    wr_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_wr_o |-> !st_empty_o) else $error("write strobe with empty buffer");

    wr_one_at_a_time: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_wr_o |-> !outstanding) else $error("second write before acknowledge");

    rd_only_clear: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_rd_o |-> (ld_busy_o && !collision)) else $error("read released while blocked");

    wr_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_wr_o |=> !mem_wr_o) else $error("write strobe wider than one cycle");

    rd_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_rd_o |=> !mem_rd_o) else $error("read strobe wider than one cycle");

    no_unknown: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({st_full_o, st_empty_o, ld_busy_o, mem_wr_o, mem_rd_o}))
        else $error("unknown value on a control output");

endmodule

bind lsu_top lsu_properties u_props (.*);

/* lsu_top.sv */
// ----------------------------------------
// LSU store path top: buffer, drain engine
// and load gate
// ----------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    flush_i,
    input  logic    st_valid_i,   // Store strobe
    input  st_req_t st_req_i,
    input  logic    ld_valid_i,   // Load strobe
    input  ld_req_t ld_req_i,
    input  logic    mem_wr_ack_i,
    output logic    st_full_o,    // Raised one entry early
    output logic    st_empty_o,
    output logic    ld_busy_o,
    output logic    mem_wr_o,
    output mem_wr_t mem_wr_req_o,
    output logic    mem_rd_o,
    output ld_req_t mem_rd_req_o
);

    st_req_t                head_entry;
    logic                   advance_head;
    logic                   collision;
    logic [`LSU_ADDR_W-1:0] check_addr;
    mem_size_t              check_size;

    store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .write_enable_i (st_valid_i),
        .advance_head_i (advance_head),
        .entry_i        (st_req_i),
        .load_addr_i    (check_addr),
        .load_size_i    (check_size),
        .head_entry_o   (head_entry),
        .empty_o        (st_empty_o),   // Also feeds the drain engine
        .full_o         (st_full_o),
        .collision_o    (collision)
    );

    store_drain u_store_drain (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .head_entry_i   (head_entry),
        .empty_i        (st_empty_o),
        .mem_wr_ack_i   (mem_wr_ack_i),
        .mem_wr_o       (mem_wr_o),
        .mem_wr_req_o   (mem_wr_req_o),
        .advance_head_o (advance_head)
    );

    load_gate u_load_gate (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .ld_valid_i     (ld_valid_i),
        .ld_req_i       (ld_req_i),
        .collision_i    (collision),
        .check_addr_o   (check_addr),
        .check_size_o   (check_size),
        .busy_o         (ld_busy_o),
        .mem_rd_o       (mem_rd_o),
        .mem_rd_req_o   (mem_rd_req_o)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lsu -f filelist.f -o sim_lsu \
    && ./obj_dir/sim_lsu | tee /dev/stderr | grep -q "TEST PASSED" \
    && exit 0 \
    || exit 1

/* store_buffer.sv */
// ----------------------------------------
// In-order store FIFO with flush, early
// full flag and load collision detector
// ----------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module store_buffer import lsu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,        // Drop every entry
    input  logic                   write_enable_i, // Store strobe from execute
    input  logic                   advance_head_i, // Head store written to memory
    input  st_req_t                entry_i,
    input  logic [`LSU_ADDR_W-1:0] load_addr_i,    // Held load to check
    input  mem_size_t              load_size_i,
    output st_req_t                head_entry_o,   // Oldest store
    output logic                   empty_o,
    output logic                   full_o,
    output logic                   collision_o     // Load overlaps a queued store
);

    localparam int num_entries = `ST_BUF_NUM_ENTRIES;
    localparam int ptr_w       = $clog2(num_entries);

    localparam mem_size_t size_h = `SIZE_H;
    localparam mem_size_t size_w = `SIZE_W;
    localparam mem_size_t size_d = `SIZE_D;
    localparam mem_size_t size_q = `SIZE_Q;

    st_req_t                entry_table [num_entries]; // Payload, no reset
    logic [num_entries-1:0] valid_table;

    logic [ptr_w-1:0] head;  // Oldest entry
    logic [ptr_w-1:0] tail;  // Next free slot
    logic [ptr_w:0]   count; // One bit wider so a full table is visible

    logic push;
    logic pop;

    // Lowest address bit compared, set by the coarser of the two sizes
    function automatic logic [2:0] align_lsb(input mem_size_t a, input mem_size_t b);
        logic [2:0] lsb;
        lsb = 3'd0; // Byte against byte, exact match
        if (a == size_q || b == size_q) begin
            lsb = 3'd4;
        end else if (a == size_d || b == size_d) begin
            lsb = 3'd3;
        end else if (a[1:0] == size_w[1:0] || b[1:0] == size_w[1:0]) begin
            lsb = 3'd2;
        end else if (a[1:0] == size_h[1:0] || b[1:0] == size_h[1:0]) begin
            lsb = 3'd1;
        end
        return lsb;
    endfunction

    assign push = write_enable_i & (count < (ptr_w+1)'(num_entries)); // Drop on true full
    assign pop  = advance_head_i & (count != '0);

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_table[tail] <= entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_table <= '0;
        end else if (flush_i) begin
            valid_table <= '0;
        end else begin
            if (push) valid_table[tail] <= 1'b1;
            if (pop)  valid_table[head] <= 1'b0;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_w'(pop);  // Wraps, depth is a power of two
            tail  <= tail + ptr_w'(push);
            count <= count + (ptr_w+1)'(push) - (ptr_w+1)'(pop);
        end
    end

    always_comb begin : collision_detector
        logic [11:0] match_mask;
        collision_o = 1'b0;
        for (int j = 0; j < num_entries; j++) begin
            // Page bits ignored, only the offset inside 4 KiB counts
            match_mask = 12'hfff << align_lsb(load_size_i, entry_table[j].size);
            if (valid_table[j] &&
                ((entry_table[j].addr[11:0] ^ load_addr_i[11:0]) & match_mask) == 12'h000) begin
                collision_o = 1'b1;
            end
        end
    end

    assign head_entry_o = (count != '0) ? entry_table[head] : '0;
    assign empty_o      = (count == '0);
    // One entry early, and held high during flush and reset
    assign full_o = (count >= (ptr_w+1)'(num_entries - 1)) | flush_i | ~rstn_i;

endmodule

/* store_drain.sv */
// ----------------------------------------
// Drain FSM writing the head store to
// memory and waiting for its acknowledge
// ----------------------------------------
`timescale 1ns/1ps

module store_drain import lsu_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    flush_i,        // Abandon write in flight
    input  st_req_t head_entry_i,   // Oldest store in the buffer
    input  logic    empty_i,
    input  logic    mem_wr_ack_i,   // One cycle acknowledge from memory
    output logic    mem_wr_o,       // One cycle write strobe
    output mem_wr_t mem_wr_req_o,
    output logic    advance_head_o  // Retire the head entry
);

    typedef enum logic {
        drain_idle,
        drain_wait  // Write issued, acknowledge pending
    } drain_state_t;

    drain_state_t state;
    logic         wr_q;
    mem_wr_t      req_q; // Held stable while waiting
    logic         issue;

    assign issue = (state == drain_idle) & ~empty_i & ~flush_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state <= drain_idle;
            wr_q  <= 1'b0;
        end else begin
            wr_q <= issue; // Strobe lasts one cycle
            if (flush_i) begin
                state <= drain_idle; // Late ack then falls into idle
            end else if (issue) begin
                state <= drain_wait;
            end else if (state == drain_wait && mem_wr_ack_i) begin
                state <= drain_idle;
            end
        end
    end

    // Capture the head entry when the write starts
    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_q.addr <= head_entry_i.addr;
            req_q.data <= head_entry_i.data;
            req_q.size <= head_entry_i.size;
        end
    end

    assign mem_wr_o       = wr_q;
    assign mem_wr_req_o   = req_q;
    assign advance_head_o = (state == drain_wait) & mem_wr_ack_i; // Ack in idle ignored

endmodule

/* tb_lsu.sv */
// ----------------------------------------
// LSU store path testbench: memory model,
// reference store queue and checks
// ----------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu import lsu_pkg::*; ();

    localparam int depth = `ST_BUF_NUM_ENTRIES;
    localparam int limit = 200; // Cycles per wait

    logic clk_i = 1'b0, rstn_i = 1'b0, flush_i = 1'b0;
    logic st_valid_i = 1'b0, ld_valid_i = 1'b0, mem_wr_ack_i = 1'b0;
    st_req_t st_req_i = '0;
    ld_req_t ld_req_i = '0;
    logic st_full_o, st_empty_o, ld_busy_o, mem_wr_o, mem_rd_o;
    mem_wr_t mem_wr_req_o;
    ld_req_t mem_rd_req_o;

    st_req_t sq[$];          // Stores still in the buffer
    ld_req_t held_ld = '0;   // Load given to the gate
    logic ld_held = 1'b0;    // Expected busy flag of the gate
    logic rd_exp;            // Held load expected out this cycle
    logic [31:0] rng = 32'd17783;
    logic in_flight = 1'b0, hold_ack = 1'b0, ack_next;
    int ack_cnt = 0, wr_count = 0, errors = 0, test_err = 0;
    int passed = 0, failed = 0, t, n;

    lsu_top dut_i (.*);

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Lowest compared address bit for one size code
    function automatic int low_bit(input mem_size_t s);
        if (s == `SIZE_Q) return 4;
        if (s == `SIZE_D) return 3;
        if (s[1:0] == 2'b10) return 2;
        return (s[1:0] == 2'b01) ? 1 : 0;
    endfunction

    function automatic logic ref_collides(input ld_req_t ld);
        int k;
        foreach (sq[i]) begin
            k = low_bit(ld.size);
            if (low_bit(sq[i].size) > k) k = low_bit(sq[i].size); // Coarser size wins
            if ((sq[i].addr[11:0] >> k) == (ld.addr[11:0] >> k)) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Monitor, memory model and reference queue update
    always @(posedge clk_i) begin
        ack_next = 1'b0;
        if (rstn_i) begin
            rd_exp = ld_held && !ref_collides(held_ld);
            assert (st_empty_o == (sq.size() == 0)) else begin
                errors++;
                $display("ERR %0t st_empty_o exp %b got %b", $time, sq.size() == 0, st_empty_o);
            end
            assert (st_full_o == (sq.size() >= depth - 1 || flush_i)) else begin
                errors++;
                $display("ERR %0t st_full_o exp %b got %b", $time, !st_full_o, st_full_o);
            end
            assert (ld_busy_o == ld_held) else begin
                errors++;
                $display("ERR %0t ld_busy_o exp %b got %b", $time, ld_held, ld_busy_o);
            end
            assert (mem_rd_o == rd_exp) else begin
                errors++;
                $display("ERR %0t mem_rd_o exp %b got %b", $time, rd_exp, mem_rd_o);
            end
            if (mem_wr_o) begin
                if (sq.size() == 0) begin
                    errors++;
                    $display("write issued with no store queued at %0t", $time);
                end else begin
                    assert (mem_wr_req_o == {sq[0].addr, sq[0].data, sq[0].size}) else begin
                        errors++;
                        $display("ERR %0t mem_wr_req_o exp %h got %h", $time,
                                 {sq[0].addr, sq[0].data, sq[0].size}, mem_wr_req_o);
                    end
                end
                in_flight = 1'b1;
                wr_count++;
                rng = xorshift(rng);
                ack_cnt = 1 + rng % 4;  // 1 to 4 cycles
            end else if (ack_cnt > 0 && !hold_ack) begin
                ack_cnt--;
                ack_next = (ack_cnt == 0);
            end
            if (flush_i) begin
                sq.delete();
                in_flight = 1'b0; // Its acknowledge is ignored
            end else begin
                if (mem_wr_ack_i && in_flight) begin
                    void'(sq.pop_front());
                    in_flight = 1'b0;
                end
                if (st_valid_i) sq.push_back(st_req_i);
            end
            if (ld_valid_i) begin
                ld_held = 1'b1;
            end else if (rd_exp) begin
                ld_held = 1'b0; // Gate lets go on this edge
            end
        end
        #1 mem_wr_ack_i = ack_next;
    end

    rd_req_match: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_rd_o |-> mem_rd_req_o == held_ld) else begin
        errors++;
        $display("ERR %0t mem_rd_req_o exp %h got %h", $time, held_ld, mem_rd_req_o);
    end

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic send_store(input logic [63:0] addr, input mem_size_t size);
        for (t = 0; st_full_o; t++) begin
            if (t > limit) give_up("st_full_o to fall");
            step();
        end
        rng = xorshift(rng);
        st_req_i = '{addr: addr, data: {rng, ~rng}, size: size, tag: rng[3:0]};
        st_valid_i = 1'b1;
        step();
        st_valid_i = 1'b0;
    endtask

    task automatic send_load(input logic [63:0] addr, input mem_size_t size);
        held_ld = '{addr: addr, size: size, tag: 4'h5};
        ld_req_i = held_ld;
        ld_valid_i = 1'b1;
        step();
        ld_valid_i = 1'b0;
    endtask

    task automatic drain_all();
        for (t = 0; !st_empty_o || sq.size() != 0 || in_flight; t++) begin
            if (t > limit) give_up("the store buffer to drain");
            step();
        end
    endtask

    task automatic report(input string name);
        if (errors == test_err) passed++;
        else failed++;
        $display("%s: %0s", name, (errors == test_err) ? "ok" : "errors");
        test_err = errors;
    endtask

    initial begin
        repeat (4) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        step();
        assert ({st_empty_o, st_full_o, mem_wr_o, mem_rd_o, ld_busy_o} == 5'b10000) else begin
            errors++;
            $display("ERR %0t {st_empty_o,st_full_o,mem_wr_o,mem_rd_o,ld_busy_o} exp %b got %b",
                     $time, 5'b10000, {st_empty_o, st_full_o, mem_wr_o, mem_rd_o, ld_busy_o});
        end
        report("reset state");

        for (n = 0; n < 20; n++) begin  // Random stores in order
            rng = xorshift(rng);
            send_store({rng, xorshift(rng)}, (rng % 5 == 4) ? `SIZE_Q : mem_size_t'(rng % 4));
        end
        drain_all();
        report("random stores");

        hold_ack = 1'b1;  // Early full
        for (n = 0; n < depth - 1; n++) send_store(64'h1000 + 8 * n, `SIZE_D);
        assert (st_full_o) else begin
            errors++;
            $display("ERR %0t st_full_o exp 1 got %b", $time, st_full_o);
        end
        hold_ack = 1'b0;
        drain_all();
        report("early full");

        hold_ack = 1'b1;  // Load with no overlap
        send_store(64'h100, `SIZE_W);
        send_store(64'h104, `SIZE_W);
        send_load(64'h200, `SIZE_B);
        assert (mem_rd_o) else begin
            errors++;
            $display("ERR %0t mem_rd_o exp 1 got %b", $time, mem_rd_o);
        end
        hold_ack = 1'b0;
        drain_all();
        report("free load");

        hold_ack = 1'b1;  // Overlap only at the doubleword grain
        send_store(64'h108, `SIZE_D);
        send_store(64'h300, `SIZE_B);
        send_load(64'h10c, `SIZE_W);
        assert (!mem_rd_o) else begin
            errors++;
            $display("ERR %0t mem_rd_o exp 0 got %b", $time, mem_rd_o);
        end
        hold_ack = 1'b0;
        for (t = 0; !mem_rd_o; t++) begin
            if (t > limit) give_up("mem_rd_o");
            step();
        end
        drain_all();
        report("colliding load");

        hold_ack = 1'b1;  // Flush with a write in flight
        for (n = 0; n < 3; n++) send_store(64'h400 + 2 * n, `SIZE_H);
        send_load(64'h400, `SIZE_H);
        for (t = 0; !in_flight; t++) begin
            if (t > limit) give_up("the first write");
            step();
        end
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        assert ({st_empty_o, mem_rd_o} == 2'b11) else begin
            errors++;
            $display("ERR %0t {st_empty_o,mem_rd_o} exp 11 got %b", $time, {st_empty_o, mem_rd_o});
        end
        n = wr_count;
        hold_ack = 1'b0;
        repeat (8) step();
        assert (wr_count == n) else begin
            errors++;
            $display("ERR %0t wr_count exp %0d got %0d", $time, n, wr_count);
        end
        report("flush");

        $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
